// ==== mem_subsys.f ====
logic/mem_pkg.sv
logic/arb_pkg.sv
logic/mem_merge.sv
logic/mem_ram.sv
logic/mem_split.sv
logic/mem_subsys.sv
sim/tb_clock.sv
sim/mem_subsys_tb.sv

// ==== Makefile ====
# Verilator flow for the shared memory port.

VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
RTL_TOP   ?= mem_subsys
FLIST     ?= mem_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

# the run passes only if the pass line shows up in the output.
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    import mem_pkg::*;
    import arb_pkg::*;

    localparam int          DRIVE_DELAY    = 10;
    localparam int          RESET_CYCLES   = 10;
    localparam int          IDLE_CYCLES    = 4;
    localparam int          NUM_ROWS       = 12;
    localparam int          WORDS_PER_PORT = MEM_DEPTH / NUM_PORTS;
    localparam int          RAND_LEN       = WORDS_PER_PORT + 40; // fill pass before mixed ops.
    localparam int          TOTAL_REQ      = NUM_ROWS + NUM_PORTS * RAND_LEN;
    localparam int          TIMEOUT_CYCLES = 20 * TOTAL_REQ + RESET_CYCLES;
    localparam logic [31:0] SEED           = 32'h4df8;

    typedef struct packed {
        logic [1:0]                port;
        mem_op_e                   op;
        logic [MEM_MASK_WIDTH-1:0] mask;
        logic [MEM_ADDR_WIDTH-1:0] addr;
        logic [MEM_DATA_WIDTH-1:0] data;
        logic [MEM_DATA_WIDTH-1:0] exp; // read data of a read row.
    } row_t;

    logic                      clk;
    logic                      arst_n;
    logic [NUM_PORTS-1:0]      req_valid;
    mem_req_t                  req [NUM_PORTS];
    logic [NUM_PORTS-1:0]      req_ready;
    logic [NUM_PORTS-1:0]      rsp_valid;
    logic [MEM_DATA_WIDTH-1:0] rsp_data;

    logic [7:0]                model_mem [MEM_DEPTH * MEM_MASK_WIDTH];
    logic [MEM_DATA_WIDTH-1:0] exp_q [NUM_PORTS][$];
    int                        reads_sent [NUM_PORTS] = '{default: 0};
    int                        strobes [NUM_PORTS] = '{default: 0};
    int                        wait_cnt [NUM_PORTS] = '{default: 0};
    int                        cycle = 0;
    mem_req_t                  rand_req [NUM_PORTS][RAND_LEN];
    logic                      rand_gap [NUM_PORTS][RAND_LEN];

    // full writes on every port, reads back, then partial-mask merges.
    row_t rows [NUM_ROWS] = '{
        '{2'd0, MEM_OP_WRITE, 4'hf, 6'd2,  32'h0a0b0c0d, 32'h0},
        '{2'd1, MEM_OP_WRITE, 4'hf, 6'd23, 32'h1a1b1c1d, 32'h0},
        '{2'd2, MEM_OP_WRITE, 4'hf, 6'd44, 32'h2a2b2c2d, 32'h0},
        '{2'd0, MEM_OP_READ,  4'hf, 6'd2,  32'h0,        32'h0a0b0c0d},
        '{2'd1, MEM_OP_READ,  4'hf, 6'd23, 32'h0,        32'h1a1b1c1d},
        '{2'd2, MEM_OP_READ,  4'hf, 6'd44, 32'h0,        32'h2a2b2c2d},
        '{2'd0, MEM_OP_WRITE, 4'hf, 6'd5,  32'h11223344, 32'h0},
        '{2'd0, MEM_OP_WRITE, 4'h5, 6'd5,  32'haabbccdd, 32'h0},
        '{2'd0, MEM_OP_READ,  4'hf, 6'd5,  32'h0,        32'h11bb33dd},
        '{2'd1, MEM_OP_WRITE, 4'h8, 6'd23, 32'hee000000, 32'h0},
        '{2'd1, MEM_OP_READ,  4'hf, 6'd23, 32'h0,        32'hee1b1c1d},
        '{2'd2, MEM_OP_READ,  4'hf, 6'd44, 32'h0,        32'h2a2b2c2d}
    };

    tb_clock #(.PERIOD_NS(100)) clock_i (.clk(clk));

    mem_subsys dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    // **************************************************
    // helpers.
    // **************************************************

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [MEM_DATA_WIDTH-1:0] model_word(input logic [MEM_ADDR_WIDTH-1:0] a);
        logic [MEM_DATA_WIDTH-1:0] w;
        for (int b = 0; b < MEM_MASK_WIDTH; b++) begin
            w[b*8 +: 8] = model_mem[int'(a) * MEM_MASK_WIDTH + b];
        end
        return w;
    endfunction

    // reads issued minus responses seen, over all ports.
    function automatic int responses_missing();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += reads_sent[p] - strobes[p];
        end
        return n;
    endfunction

    // transfers reach the RAM in order, so the model is updated here.
    task automatic record_transfer(input int p, input mem_req_t r);
        if (r.op == MEM_OP_WRITE) begin
            for (int b = 0; b < MEM_MASK_WIDTH; b++) begin
                if (r.mask[b]) model_mem[int'(r.addr) * MEM_MASK_WIDTH + b] = r.data[b*8 +: 8];
            end
        end else begin
            exp_q[p].push_back(model_word(r.addr));
        end
    endtask

    task automatic wait_transfer(input int p);
        do @(negedge clk); while (!req_ready[p]);
    endtask

    task automatic apply_row(input row_t r);
        int xfer_cyc;
        req[r.port]       = '{op: r.op, mask: r.mask, addr: r.addr, data: r.data, id: '0};
        req_valid[r.port] = 1'b1;
        if (r.op == MEM_OP_READ) begin
            reads_sent[r.port]++;
        end
        wait_transfer(int'(r.port));
        xfer_cyc = cycle;
        @(posedge clk);
        #DRIVE_DELAY;
        req_valid[r.port] = 1'b0;
        if (r.op == MEM_OP_READ) begin
            do @(negedge clk); while (rsp_valid == '0);
            check_value("rsp_valid", 32'(rsp_valid), 32'(1) << r.port);
            check_value("rsp_data", rsp_data, r.exp);
            check_value("rsp_latency", cycle - xfer_cyc, 3);
        end
        repeat (IDLE_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic build_random();
        logic [31:0] rng;
        logic [31:0] r;
        int          offs;
        rng = SEED;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < RAND_LEN; i++) begin
                rng  = xorshift32(rng);
                r    = rng;
                rng  = xorshift32(rng);
                offs = (i < WORDS_PER_PORT) ? i : int'(r[15:8]) % WORDS_PER_PORT;
                rand_req[p][i].op   = (i < WORDS_PER_PORT || r[0]) ? MEM_OP_WRITE : MEM_OP_READ;
                rand_req[p][i].mask = (i < WORDS_PER_PORT || r[1]) ? '1 : r[5:2];
                rand_req[p][i].addr = MEM_ADDR_WIDTH'(p * WORDS_PER_PORT + offs); // own third.
                rand_req[p][i].data = rng;
                rand_req[p][i].id   = '0;
                rand_gap[p][i]      = r[16];
            end
        end
    endtask

    task automatic drive_port(input int p);
        for (int i = 0; i < RAND_LEN; i++) begin
            req[p]       = rand_req[p][i];
            req_valid[p] = 1'b1;
            if (rand_req[p][i].op == MEM_OP_READ) begin
                reads_sent[p]++;
            end
            wait_transfer(p);
            @(posedge clk);
            #DRIVE_DELAY;
            if (rand_gap[p][i]) begin
                req_valid[p] = 1'b0;
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        req_valid[p] = 1'b0;
    endtask

    // **************************************************
    // monitors.
    // **************************************************

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timed out after %0d cycles waiting for the DUT", cycle));
        end
    end

    always @(negedge clk) begin : watch_bus
        logic [NUM_PORTS-1:0] xfer;
        if (arst_n) begin
            xfer = req_valid & req_ready;
            if ($countones(rsp_valid) > 1) abort_run("response strobed on more than one port");
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rsp_valid[p]) begin
                    if (exp_q[p].size() == 0) begin
                        abort_run($sformatf("response on port %0d with no read pending", p));
                    end
                    check_value("rsp_data", rsp_data, exp_q[p].pop_front());
                    strobes[p]++;
                end
                if (xfer[p]) record_transfer(p, req[p]);
                // round robin lets at most NUM_PORTS-1 others go first.
                if (!req_valid[p] || xfer[p]) begin
                    wait_cnt[p] = 0;
                end else if (xfer != '0) begin
                    wait_cnt[p]++;
                    if (wait_cnt[p] > NUM_PORTS - 1) begin
                        abort_run($sformatf("port %0d starved by the arbiter", p));
                    end
                end
            end
        end
    end

    // **************************************************
    // main sequence.
    // **************************************************

    initial begin
        arst_n    = 1'b0;
        req_valid = '0;
        foreach (req[p]) req[p] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("rsp_valid", 32'(rsp_valid), 32'h0);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        foreach (rows[i]) apply_row(rows[i]);
        build_random();
        fork
            drive_port(0);
            drive_port(1);
            drive_port(2);
        join
        while (responses_missing() > 0) @(negedge clk);
        repeat (IDLE_CYCLES) @(negedge clk); // no late strobes.
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("rsp_valid[%0d] count", p), strobes[p], reads_sent[p]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk; // free running.
    end

endmodule

`default_nettype wire

// ==== logic/mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input  logic                               clk,
    input  logic                               arst_n,

    input  logic [arb_pkg::NUM_PORTS-1:0]      req_valid,
    input  mem_pkg::mem_req_t                  req [arb_pkg::NUM_PORTS],
    output logic [arb_pkg::NUM_PORTS-1:0]      req_ready,

    output logic [arb_pkg::NUM_PORTS-1:0]      rsp_valid,
    output logic [mem_pkg::MEM_DATA_WIDTH-1:0] rsp_data
);

    import mem_pkg::*;

    logic     merge_valid;
    mem_req_t merge_req;
    logic     ram_ready;
    logic     ram_rsp_valid;
    mem_rsp_t ram_rsp;

    // **************************************************
    // request path.
    // **************************************************

    mem_merge #(
        .PIPELINE_MODE(1)
    ) merge_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (req_valid),
        .in_req    (req),
        .in_ready  (req_ready),
        .out_valid (merge_valid),
        .out_req   (merge_req),
        .out_ready (ram_ready)
    );

    mem_ram ram_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (merge_valid),
        .req       (merge_req),
        .req_ready (ram_ready),
        .rsp_valid (ram_rsp_valid),
        .rsp       (ram_rsp)
    );

    // **************************************************
    // response path.
    // **************************************************

    mem_split split_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (ram_rsp_valid),
        .in_rsp    (ram_rsp),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

endmodule

`default_nettype wire

// ==== logic/mem_split.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_split (
    input  logic                                clk,
    input  logic                                arst_n,

    input  logic                                in_valid,
    input  mem_pkg::mem_rsp_t                   in_rsp,

    output logic [arb_pkg::NUM_PORTS-1:0]       rsp_valid,
    output logic [mem_pkg::MEM_DATA_WIDTH-1:0]  rsp_data
);

    import mem_pkg::*;
    import arb_pkg::*;

    logic     valid_q;
    mem_rsp_t rsp_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            rsp_q <= in_rsp;
        end
    end

    // id to one-hot strobe.
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rsp_valid[p] = valid_q && (rsp_q.id == MEM_ID_WIDTH'(p));
        end
    end

    assign rsp_data = rsp_q.data; // shared by all ports.

    // ids come from the merge tag.
    a_id_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> int'(in_rsp.id) < NUM_PORTS);

endmodule

`default_nettype wire

// ==== logic/mem_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_ram (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              req_valid,
    input  mem_pkg::mem_req_t req,
    output logic              req_ready,

    output logic              rsp_valid,
    output mem_pkg::mem_rsp_t rsp
);

    import mem_pkg::*;

    typedef enum logic {
        RAM_IDLE  = 1'b0,
        RAM_MERGE = 1'b1
    } ram_state_e;

    ram_state_e                state_q;
    logic [MEM_DATA_WIDTH-1:0] mem_q [MEM_DEPTH];
    logic                      accept;
    logic                      partial_wr;
    mem_req_t                  hold_req_q;
    logic [MEM_DATA_WIDTH-1:0] rd_word_q;
    logic [MEM_DATA_WIDTH-1:0] merged_word;
    logic                      wr_en;
    logic [MEM_ADDR_WIDTH-1:0] wr_addr;
    logic [MEM_DATA_WIDTH-1:0] wr_data;

    assign req_ready  = (state_q == RAM_IDLE);
    assign accept     = req_valid && req_ready;
    assign partial_wr = (req.op == MEM_OP_WRITE) && !(&req.mask);

    // **************************************************
    // control.
    // **************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= RAM_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= accept && (req.op == MEM_OP_READ);
            case (state_q)
                RAM_IDLE: begin
                    if (accept && partial_wr) begin
                        state_q <= RAM_MERGE;
                    end
                end
                default: begin
                    state_q <= RAM_IDLE; // write-back done.
                end
            endcase
        end
    end

    // **************************************************
    // datapath.
    // **************************************************

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_req_q <= req;
            rd_word_q  <= mem_q[req.addr];
        end
    end

    always_comb begin
        for (int b = 0; b < MEM_MASK_WIDTH; b++) begin
            merged_word[b*8 +: 8] = hold_req_q.mask[b] ? hold_req_q.data[b*8 +: 8]
                                                      : rd_word_q[b*8 +: 8];
        end
    end

    // merge write-back has priority on the single write port.
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = req.addr;
        wr_data = req.data;
        if (state_q == RAM_MERGE) begin
            wr_en   = 1'b1;
            wr_addr = hold_req_q.addr;
            wr_data = merged_word;
        end else if (accept && (req.op == MEM_OP_WRITE) && !partial_wr) begin
            wr_en = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_addr] <= wr_data;
        end
    end

    assign rsp = '{id: hold_req_q.id, data: rd_word_q};

    // upstream holds its request through the stall.
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

// ==== logic/mem_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_merge #(
    parameter int PIPELINE_MODE = 1
) (
    input  logic                           clk,
    input  logic                           arst_n,

    input  logic [arb_pkg::NUM_PORTS-1:0]  in_valid,
    input  mem_pkg::mem_req_t              in_req [arb_pkg::NUM_PORTS],
    output logic [arb_pkg::NUM_PORTS-1:0]  in_ready,

    output logic                           out_valid,
    output mem_pkg::mem_req_t              out_req,
    input  logic                           out_ready
);

    import mem_pkg::*;
    import arb_pkg::*;

    logic [PORT_ID_WIDTH-1:0] last_q;     // last granted port.
    logic [PORT_ID_WIDTH-1:0] grant_idx;
    logic                     any_valid;
    logic                     lock_q;
    logic [PORT_ID_WIDTH-1:0] lock_idx_q;
    logic                     stage_ready;
    mem_req_t                 tagged_req;

    // **************************************************
    // round-robin arbitration.
    // **************************************************

    // lowest offset from last_q wins, so scan downwards.
    always_comb begin
        int cand;
        any_valid = 1'b0;
        grant_idx = '0;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            cand = (int'(last_q) + i) % NUM_PORTS;
            if (in_valid[cand]) begin
                any_valid = 1'b1;
                grant_idx = PORT_ID_WIDTH'(cand);
            end
        end
        // a stalled winner keeps the grant.
        if (lock_q) begin
            grant_idx = lock_idx_q;
        end
    end

    always_comb begin
        tagged_req    = in_req[grant_idx];
        tagged_req.id = MEM_ID_WIDTH'(grant_idx); // tag with port number.
    end

    always_comb begin
        in_ready            = '0;
        in_ready[grant_idx] = any_valid && stage_ready;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q     <= PORT_ID_WIDTH'(NUM_PORTS - 1); // port 0 first.
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= any_valid && !stage_ready;
            lock_idx_q <= grant_idx;
            if (any_valid && stage_ready) begin
                last_q <= grant_idx;
            end
        end
    end

    // **************************************************
    // output stage.
    // **************************************************

    generate
        if (PIPELINE_MODE != 0) begin : g_stage
            merge_stage_e stage_q;
            mem_req_t     stage_req_q;

            // free when empty or draining this edge.
            assign stage_ready = (stage_q == STAGE_EMPTY) || out_ready;
            assign out_valid   = (stage_q == STAGE_FULL);
            assign out_req     = stage_req_q;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    stage_q <= STAGE_EMPTY;
                end else if (stage_ready) begin
                    stage_q <= any_valid ? STAGE_FULL : STAGE_EMPTY;
                end
            end

            always_ff @(posedge clk) begin
                if (any_valid && stage_ready) begin
                    stage_req_q <= tagged_req;
                end
            end
        end else begin : g_bypass
            assign stage_ready = out_ready;
            assign out_valid   = any_valid;
            assign out_req     = tagged_req;
        end
    endgenerate

    // grants only go to requesting ports.
    a_grant_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (in_ready & ~in_valid) == '0);

    // downstream sees a steady request until it takes it.
    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_req));

endmodule

`default_nettype wire

// ==== logic/arb_pkg.sv ====
`default_nettype none

package arb_pkg;

    // **************************************************
    // request ports.
    // **************************************************

    localparam int NUM_PORTS     = 3;
    localparam int PORT_ID_WIDTH = $clog2(NUM_PORTS);

    // merge output register.
    typedef enum logic {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL  = 1'b1
    } merge_stage_e;

endpackage

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // **************************************************
    // transaction widths.
    // **************************************************

    localparam int MEM_ADDR_WIDTH = 6;                 // word address.
    localparam int MEM_DEPTH      = 2 ** MEM_ADDR_WIDTH;
    localparam int MEM_DATA_WIDTH = 32;
    localparam int MEM_MASK_WIDTH = MEM_DATA_WIDTH / 8; // one bit per byte.
    localparam int MEM_ID_WIDTH   = 2;

    // **************************************************
    // opcodes and payloads.
    // **************************************************

    typedef enum logic {
        MEM_OP_READ  = 1'b0,
        MEM_OP_WRITE = 1'b1
    } mem_op_e;

    // id is left zero by the requester.
    typedef struct packed {
        mem_op_e                   op;
        logic [MEM_MASK_WIDTH-1:0] mask;
        logic [MEM_ADDR_WIDTH-1:0] addr;
        logic [MEM_DATA_WIDTH-1:0] data;
        logic [MEM_ID_WIDTH-1:0]   id;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_ID_WIDTH-1:0]   id;
        logic [MEM_DATA_WIDTH-1:0] data;
    } mem_rsp_t;

endpackage

`default_nettype wire
